// File: logic/nn_params.svh
`ifndef NN_PARAMS_SVH
`define NN_PARAMS_SVH

// Layer shape
`define NN_INPUTS 10
`define NN_NEURONS 4

// Fixed-point widths
`define NN_DATA_W 8
`define NN_ACC_W 23
`define NN_FRAC_BITS 6
`define NN_OUT_MAX 127

`endif

// File: logic/nn_pkg.sv
`default_nettype none

`include "nn_params.svh"

package nn_pkg;

	typedef logic signed [`NN_DATA_W-1:0] act_t;
	typedef logic signed [`NN_DATA_W-1:0] weight_t;
	typedef logic signed [`NN_ACC_W-1:0] acc_t;
	typedef logic [$clog2(`NN_NEURONS)-1:0] neuron_idx_t;
	typedef logic [3:0] input_idx_t;

	// One inference worth of activations
	typedef struct packed {
		act_t [`NN_INPUTS-1:0] a;
	} act_vec_s;

	// Coefficient set of a single neuron
	typedef struct packed {
		weight_t [`NN_INPUTS-1:0] w;
		weight_t bias;
	} weight_vec_s;

	// Single host write where bias_sel picks the bias over a weight
	typedef struct packed {
		neuron_idx_t neuron;
		input_idx_t in_idx;
		logic bias_sel;
		weight_t value;
	} coef_wr_s;

	typedef struct packed {
		act_t [`NN_NEURONS-1:0] outs;
		neuron_idx_t winner;
	} layer_out_s;

endpackage

`default_nettype wire

// File: logic/weight_bank.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module weight_bank
(
	input logic clk,
	input logic reset,
	input logic coef_wr_en,
	input nn_pkg::coef_wr_s coef_wr,
	output nn_pkg::weight_vec_s coefs [`NN_NEURONS]
);

	logic [`NN_NEURONS-1:0] neuron_hit;
	logic [`NN_INPUTS-1:0] input_hit;
	logic in_range;
	logic weight_wr;
	logic bias_wr;

	// Address decode of the host write
	always_comb
	begin
		in_range = (coef_wr.in_idx < nn_pkg::input_idx_t'(`NN_INPUTS));
		weight_wr = !coef_wr.bias_sel && in_range;
		bias_wr = coef_wr.bias_sel;

		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			neuron_hit[n] = coef_wr_en && (coef_wr.neuron == nn_pkg::neuron_idx_t'(n));
		end

		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			input_hit[i] = weight_wr && (coef_wr.in_idx == nn_pkg::input_idx_t'(i));
		end
	end

	// One coefficient register set per neuron
	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : g_neuron
		always_ff @(posedge clk)
		begin
			if (reset)
			begin
				coefs[n] <= '0;
			end
			else if (neuron_hit[n])
			begin
				if (bias_wr)
				begin
					coefs[n].bias <= coef_wr.value;
				end
				for (int i = 0; i < `NN_INPUTS; i++)
				begin
					if (input_hit[i])
					begin
						coefs[n].w[i] <= coef_wr.value;
					end
				end
			end
		end
	end

endmodule

`default_nettype wire

// File: logic/neuron_mac.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module neuron_mac
(
	input logic clk,
	input logic reset,
	input logic act_valid,
	input nn_pkg::act_vec_s act,
	input nn_pkg::weight_vec_s coef,
	output logic out_valid,
	output nn_pkg::act_t out
);

	localparam int PROD_W = 2 * `NN_DATA_W;

	nn_pkg::act_vec_s act_q;
	nn_pkg::weight_vec_s coef_q;
	logic valid_q;

	logic signed [PROD_W-1:0] prod [`NN_INPUTS];
	nn_pkg::acc_t acc_sum;
	nn_pkg::acc_t acc_q;
	logic acc_valid_q;

	nn_pkg::acc_t acc_shift;
	nn_pkg::acc_t acc_round;
	nn_pkg::act_t out_next;

	// Stage 1 captures the operands
	always_ff @(posedge clk)
	begin
		if (act_valid)
		begin
			act_q <= act;
			coef_q <= coef;
		end
	end

	// Products plus bias scaled up to the accumulator's fraction
	always_comb
	begin
		acc_sum = nn_pkg::acc_t'(coef_q.bias) <<< `NN_FRAC_BITS;
		for (int i = 0; i < `NN_INPUTS; i++)
		begin
			prod[i] = act_q.a[i] * coef_q.w[i];
			acc_sum = acc_sum + nn_pkg::acc_t'(prod[i]);
		end
	end

	// Stage 2
	always_ff @(posedge clk)
	begin
		if (valid_q)
		begin
			acc_q <= acc_sum;
		end
	end

	// ReLU, then round half up, then clamp
	always_comb
	begin
		acc_shift = acc_q >>> `NN_FRAC_BITS;
		acc_round = acc_shift + nn_pkg::acc_t'({1'b0, acc_q[`NN_FRAC_BITS-1]});
		if (acc_q[`NN_ACC_W-1])
			out_next = '0;
		else if (acc_round > nn_pkg::acc_t'(`NN_OUT_MAX))
			out_next = nn_pkg::act_t'(`NN_OUT_MAX);
		else
			out_next = nn_pkg::act_t'(acc_round);
	end

	// Stage 3 and the valid pipe
	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			valid_q <= 1'b0;
			acc_valid_q <= 1'b0;
			out_valid <= 1'b0;
			out <= '0;
		end
		else
		begin
			valid_q <= act_valid;
			acc_valid_q <= valid_q;
			out_valid <= acc_valid_q;
			if (acc_valid_q)
				out <= out_next;
		end
	end

endmodule

`default_nettype wire

// File: logic/argmax_select.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module argmax_select
(
	input logic clk,
	input logic reset,
	input logic in_valid,
	input nn_pkg::act_t outs [`NN_NEURONS],
	output logic result_valid,
	output nn_pkg::layer_out_s result
);

	typedef struct packed {
		nn_pkg::act_t val;
		nn_pkg::neuron_idx_t idx;
	} cand_s;

	cand_s leaf [`NN_NEURONS];
	cand_s pair_lo;
	cand_s pair_hi;
	cand_s best;
	nn_pkg::layer_out_s result_d;

	// Upper candidate wins only when strictly larger
	function automatic cand_s pick_max(cand_s lo, cand_s hi);
		if (hi.val > lo.val)
			return hi;
		return lo;
	endfunction

	always_comb
	begin
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			leaf[n].val = outs[n];
			leaf[n].idx = nn_pkg::neuron_idx_t'(n);
			result_d.outs[n] = outs[n];
		end
		pair_lo = pick_max(leaf[0], leaf[1]);
		pair_hi = pick_max(leaf[2], leaf[3]);
		best = pick_max(pair_lo, pair_hi);
		result_d.winner = best.idx;
	end

	always_ff @(posedge clk)
	begin
		if (reset)
		begin
			result_valid <= 1'b0;
			result <= '0;
		end
		else
		begin
			result_valid <= in_valid;
			if (in_valid)
				result <= result_d;
		end
	end

endmodule

`default_nettype wire

// File: logic/dense_layer.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module dense_layer
(
	input logic clk,
	input logic reset,
	input logic coef_wr_en,
	input nn_pkg::coef_wr_s coef_wr,
	input logic act_valid,
	input nn_pkg::act_vec_s act,
	output logic result_valid,
	output nn_pkg::layer_out_s result
);

	nn_pkg::weight_vec_s coefs [`NN_NEURONS];
	nn_pkg::act_t neuron_out [`NN_NEURONS];
	logic [`NN_NEURONS-1:0] neuron_valid;

	weight_bank u_weight_bank
	(
		.clk (clk),
		.reset (reset),
		.coef_wr_en (coef_wr_en),
		.coef_wr (coef_wr),
		.coefs (coefs)
	);

	// Activations broadcast to every neuron
	for (genvar n = 0; n < `NN_NEURONS; n++)
	begin : g_neuron
		neuron_mac u_neuron_mac
		(
			.clk (clk),
			.reset (reset),
			.act_valid (act_valid),
			.act (act),
			.coef (coefs[n]),
			.out_valid (neuron_valid[n]),
			.out (neuron_out[n])
		);
	end

	// All neurons run in lockstep, so neuron 0 stands for the rest
	argmax_select u_argmax_select
	(
		.clk (clk),
		.reset (reset),
		.in_valid (neuron_valid[0]),
		.outs (neuron_out),
		.result_valid (result_valid),
		.result (result)
	);

endmodule

`default_nettype wire

// File: dv/dense_layer_checker.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module dense_layer_checker
(
	input logic clk,
	input logic reset,
	input logic act_valid,
	input logic result_valid,
	input nn_pkg::layer_out_s result
);

	int fail_count = 0;
	logic any_negative;
	logic winner_is_max;

	always_comb
	begin
		any_negative = 1'b0;
		winner_is_max = 1'b1;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			if (result.outs[n][`NN_DATA_W-1])
				any_negative = 1'b1;
			if ($signed(result.outs[n]) > $signed(result.outs[result.winner]))
				winner_is_max = 1'b0;
		end
	end

	// Quiet through reset and the first cycle after it
	a_reset_quiet: assert property (@(posedge clk) reset |=> !result_valid)
	else
	begin
		fail_count++;
		$error("result_valid high during or right after reset");
	end

	// Registered at the third edge after E0, so seen in sampled values one edge later
	a_latency_fwd: assert property (@(posedge clk) disable iff (reset)
		act_valid |-> ##4 result_valid)
	else
	begin
		fail_count++;
		$error("result_valid missing three edges after act_valid");
	end

	a_latency_bwd: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> $past(act_valid, 4))
	else
	begin
		fail_count++;
		$error("result_valid without a matching act_valid");
	end

	a_no_negative: assert property (@(posedge clk) disable iff (reset) !any_negative)
	else
	begin
		fail_count++;
		$error("negative neuron output");
	end

	a_winner_max: assert property (@(posedge clk) disable iff (reset)
		result_valid |-> winner_is_max)
	else
	begin
		fail_count++;
		$error("winner output is smaller than another output");
	end

endmodule

bind dense_layer dense_layer_checker chk0
(
	.clk (clk),
	.reset (reset),
	.act_valid (act_valid),
	.result_valid (result_valid),
	.result (result)
);

`default_nettype wire

// File: dv/dense_layer_tb.sv
`timescale 1ns/1ps
`default_nettype none

`include "nn_params.svh"

module dense_layer_tb;

	localparam int DRAIN_TIMEOUT = 50;

	logic clk;
	logic reset;
	logic coef_wr_en;
	nn_pkg::coef_wr_s coef_wr;
	logic act_valid;
	nn_pkg::act_vec_s act;
	logic result_valid;
	nn_pkg::layer_out_s result;

	int seed = 32'hcf89_b81d;
	int mismatches = 0;
	int timeouts = 0;
	int shadow_w [`NN_NEURONS][`NN_INPUTS] = '{default: 0};
	int shadow_bias [`NN_NEURONS] = '{default: 0};
	nn_pkg::layer_out_s pending [$];
	nn_pkg::layer_out_s want;

	dense_layer dut0
	(
		.clk (clk),
		.reset (reset),
		.coef_wr_en (coef_wr_en),
		.coef_wr (coef_wr),
		.act_valid (act_valid),
		.act (act),
		.result_valid (result_valid),
		.result (result)
	);

	always #10 clk = ~clk;

	// Reference neuron and argmax rules on the shadow coefficients
	function automatic nn_pkg::layer_out_s expected_result(nn_pkg::act_vec_s v);
		nn_pkg::layer_out_s r;
		int sum;
		int q;
		r = '0;
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			sum = shadow_bias[n] * (1 << `NN_FRAC_BITS);
			for (int i = 0; i < `NN_INPUTS; i++)
				sum += int'($signed(v.a[i])) * shadow_w[n][i];
			q = (sum < 0) ? 0 : (sum + (1 << (`NN_FRAC_BITS - 1))) / (1 << `NN_FRAC_BITS);
			if (q > `NN_OUT_MAX)
				q = `NN_OUT_MAX;
			r.outs[n] = nn_pkg::act_t'(q);
			// Strictly larger only, so ties stay with the lower index
			if (q > int'(r.outs[r.winner]))
				r.winner = nn_pkg::neuron_idx_t'(n);
		end
		return r;
	endfunction

	function automatic int random_byte();
		int r;
		r = $random(seed);
		return int'($signed(nn_pkg::act_t'(r)));
	endfunction

	function automatic nn_pkg::act_vec_s random_vector();
		nn_pkg::act_vec_s v;
		for (int i = 0; i < `NN_INPUTS; i++)
			v.a[i] = nn_pkg::act_t'(random_byte());
		return v;
	endfunction

	function automatic nn_pkg::act_vec_s pair_vector(int a0, int a1);
		nn_pkg::act_vec_s v;
		v = '0;
		v.a[0] = nn_pkg::act_t'(a0);
		v.a[1] = nn_pkg::act_t'(a1);
		return v;
	endfunction

	task automatic write_coef(int n, int idx, bit bias_sel, int value);
		coef_wr.neuron = nn_pkg::neuron_idx_t'(n);
		coef_wr.in_idx = nn_pkg::input_idx_t'(idx);
		coef_wr.bias_sel = bias_sel;
		coef_wr.value = nn_pkg::weight_t'(value);
		coef_wr_en = 1'b1;
		if (bias_sel)
			shadow_bias[n] = int'($signed(coef_wr.value));
		else if (idx < `NN_INPUTS)
			shadow_w[n][idx] = int'($signed(coef_wr.value));
		@(negedge clk);
		coef_wr_en = 1'b0;
	endtask

	task automatic fill_coefs(bit use_random);
		for (int n = 0; n < `NN_NEURONS; n++)
		begin
			write_coef(n, 0, 1'b1, use_random ? random_byte() : 0);
			for (int i = 0; i < `NN_INPUTS; i++)
				write_coef(n, i, 1'b0, use_random ? random_byte() : 0);
		end
	endtask

	task automatic send_vector(nn_pkg::act_vec_s v);
		act = v;
		act_valid = 1'b1;
		pending.push_back(expected_result(v));
		@(negedge clk);
		act_valid = 1'b0;
	endtask

	task automatic wait_results();
		int cycles;
		cycles = 0;
		while (pending.size() > 0 && cycles < DRAIN_TIMEOUT)
		begin
			@(posedge clk);
			cycles++;
		end
		@(negedge clk);
		if (pending.size() > 0)
		begin
			$display("Timeout at %0t: %0d results never arrived", $time, pending.size());
			timeouts++;
			pending.delete();
		end
	endtask

	// Scoreboard on the falling edge where outputs are stable
	always @(negedge clk)
	begin
		if (!reset && result_valid)
		begin
			assert (pending.size() > 0)
			else
			begin
				mismatches++;
				$display("Result at %0t arrived with no vector pending", $time);
			end
			if (pending.size() > 0)
			begin
				want = pending.pop_front();
				assert (result == want)
				else
				begin
					mismatches++;
					$display("FAILED at %0t: outs %h winner %0d, expected outs %h winner %0d",
						$time, result.outs, result.winner, want.outs, want.winner);
				end
			end
		end
	end

	initial
	begin
		clk = 1'b0;
		reset = 1'b1;
		coef_wr_en = 1'b0;
		coef_wr = '0;
		act_valid = 1'b0;
		act = '0;
		repeat (16) @(negedge clk);
		reset = 1'b0;
		@(negedge clk);

		// Zero coefficients straight out of reset
		repeat (3) send_vector(random_vector());
		wait_results();

		// 96/64 is an exact half, 31 and 62 and 127 land either side
		write_coef(0, 0, 1'b0, 1);
		write_coef(1, 1, 1'b0, 1);
		write_coef(2, 1, 1'b0, 2);
		write_coef(3, 0, 1'b0, 1);
		write_coef(3, 1, 1'b0, 1);
		send_vector(pair_vector(96, 31));
		wait_results();

		// ReLU, overflow, and 8191 which rounds to 128
		fill_coefs(1'b0);
		write_coef(0, 0, 1'b0, -1);
		write_coef(1, 0, 1'b0, 127);
		write_coef(2, 1, 1'b0, 1);
		write_coef(2, 0, 1'b1, 127);
		write_coef(3, 0, 1'b1, -5);
		send_vector(pair_vector(127, 63));
		wait_results();

		// Bias only, then weight writes past the last input
		fill_coefs(1'b0);
		write_coef(1, 0, 1'b1, 37);
		send_vector(pair_vector(50, -20));
		for (int i = `NN_INPUTS; i < 16; i++)
			write_coef(i % `NN_NEURONS, i, 1'b0, 100);
		send_vector(pair_vector(50, -20));
		wait_results();

		fill_coefs(1'b1);
		repeat (40) send_vector(random_vector());
		wait_results();

		// Neuron 3 copies neuron 1 to force ties
		write_coef(3, 0, 1'b1, shadow_bias[1]);
		for (int i = 0; i < `NN_INPUTS; i++)
			write_coef(3, i, 1'b0, shadow_w[1][i]);
		repeat (40) send_vector(random_vector());
		wait_results();

		repeat (5) @(negedge clk);
		$display("Errors: %0d mismatches, %0d timeouts, %0d assertion failures",
			mismatches, timeouts, dut0.chk0.fail_count);
		if (mismatches + timeouts + dut0.chk0.fail_count == 0)
			$display("all tests passed");
		else
			$display("tests failed");
		$finish;
	end

endmodule

`default_nettype wire

// File: build.f
+incdir+logic
logic/nn_pkg.sv
logic/weight_bank.sv
logic/neuron_mac.sv
logic/argmax_select.sv
logic/dense_layer.sv
dv/dense_layer_checker.sv
dv/dense_layer_tb.sv

// File: Makefile
TOP := dense_layer_tb
LOG := sim.log

.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only -Wall +incdir+logic --top-module dense_layer \
		logic/nn_pkg.sv logic/weight_bank.sv logic/neuron_mac.sv \
		logic/argmax_select.sv logic/dense_layer.sv

sim:
	verilator --binary --timing --assert -f build.f --top-module $(TOP) -o $(TOP)
	./obj_dir/$(TOP) | tee $(LOG)
	@grep -qx "all tests passed" $(LOG) && echo "PASS" || (echo "FAIL, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)
